// File: dv/pce_io_stimulus.txt
# op a b c name, all values in hex; cjy/cal/car compare a with joy_in/audio_l/audio_r
# cfg bits 5:0 = lbtn rbtn swap turbotap buttons6 mouse_en; unused fields are 0
pad 0 0A5 0 none
pad 1 3C1 0 none
pad 2 012 0 none
pad 3 030 0 none
pad 4 070 0 none
joy 0 0 0 none
cjy 5 0 0 pad0_buttons
joy 1 0 0 none
cjy 9 0 0 pad0_dirs
joy 0 0 0 none
cfg 8 0 0 none
cjy 3 0 0 swap_buttons
joy 1 0 0 none
cjy D 0 0 swap_dirs
joy 0 0 0 none
cfg 4 0 0 none
clr 0 0 0 none
cjy 5 0 0 tap_port0
sel 0 0 0 none
cjy 3 0 0 tap_port1
sel 0 0 0 none
cjy E 0 0 tap_port2
sel 0 0 0 none
cjy C 0 0 tap_port3
sel 0 0 0 none
cjy 8 0 0 tap_port4
sel 0 0 0 none
cjy F 0 0 tap_port5
sel 0 0 0 none
cjy F 0 0 tap_port6
cfg 0 0 0 none
clr 0 0 0 none
sel 0 0 0 none
cjy 5 0 0 no_tap_port0
pad 0 6A5 0 none
cfg 2 0 0 none
clr 0 0 0 none
cjy 9 0 0 six_btn_extras
joy 1 0 0 none
cjy 0 0 0 six_btn_ones
joy 0 0 0 none
clr 0 0 0 none
cjy 5 0 0 six_btn_low_again
cfg 0 0 0 none
clr 0 0 0 none
clr 0 0 0 none
cjy 5 0 0 no_six_btn
idle 8100 0 0 none
cfg 21 0 0 none
mse 005 012 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy F 0 0 mouse_x_high
joy 0 0 0 none
cjy 5 0 0 mouse_btns
clr 0 0 0 none
joy 1 0 0 none
cjy B 0 0 mouse_x_low
joy 0 0 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy 1 0 0 mouse_y_high
joy 0 0 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy 2 0 0 mouse_y_low
joy 0 0 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy 0 0 0 mouse_cleared
joy 0 0 0 none
clr 0 0 0 none
mse 1F0 034 0 none
idle 8100 0 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy 1 0 0 mouse_restart_x_high
joy 0 0 0 none
clr 0 0 0 none
joy 1 0 0 none
cjy 0 0 0 mouse_restart_x_low
joy 0 0 0 none
aul 01000 02000 0010 none
aur 00000 FFF00 0 none
cal 83100 0 0 mix_left
car 80000 0 0 mix_right_zero
aul 3FFFF 3FFFF 0 none
cal FFFFE 0 0 mix_top_in_range
aul 7FFFF 7FFFF 0 none
aur 80000 80000 0 none
cal FFFFF 0 0 sat_positive
car 00000 0 0 sat_negative

// File: tb.f
src/pce_io_pkg.sv
src/pad_port.sv
src/mouse_port.sv
src/audio_mixer.sv
src/pce_io_top.sv
dv/tb_clock.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator from the project root
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 || { echo "Build or simulation error"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	logic                            clk_sys;
	logic                            rst_n;
	pce_io_pkg::pad_buttons_t        pad [5];
	logic                            swap;
	logic                            turbotap;
	logic                            buttons6;
	logic                            mouse_en;
	logic                            mouse_lbtn;
	logic                            mouse_rbtn;
	logic [8:0]                      mouse_x;
	logic [8:0]                      mouse_y;
	logic                            mouse_strobe;
	logic [1:0]                      joy_out;
	pce_io_pkg::nibble_t             joy_in;
	pce_io_pkg::wide_sample_t        psg_l;
	pce_io_pkg::wide_sample_t        psg_r;
	pce_io_pkg::wide_sample_t        cdda_l;
	pce_io_pkg::wide_sample_t        cdda_r;
	pce_io_pkg::adpcm_sample_t       adpcm;
	pce_io_pkg::dac_sample_t         audio_l;
	pce_io_pkg::dac_sample_t         audio_r;
	int                              errors;

	tb_clock u_clock (.clk_sys(clk_sys), .rst_n(rst_n));

	pce_io_top dut (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.pad_0(pad[0]), .pad_1(pad[1]), .pad_2(pad[2]), .pad_3(pad[3]), .pad_4(pad[4]),
		.swap(swap), .turbotap(turbotap), .buttons6(buttons6), .mouse_en(mouse_en),
		.mouse_lbtn(mouse_lbtn), .mouse_rbtn(mouse_rbtn),
		.mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_strobe(mouse_strobe),
		.joy_out(joy_out), .joy_in(joy_in),
		.psg_l(psg_l), .psg_r(psg_r), .cdda_l(cdda_l), .cdda_r(cdda_r), .adpcm(adpcm),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Inputs move 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic pulse_joy(input int idx);
		joy_out[idx] = 1'b1;
		next_cycle();
		joy_out[idx] = 1'b0;
		next_cycle();
	endtask

	// ========================================
	// Stimulus file player
	// ========================================

	initial begin
		int          fd;
		int          code;
		int          cnt;
		int          lines;
		string       line;
		string       op;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;

		errors = 0;
		foreach (pad[i]) pad[i] = '0;
		{swap, turbotap, buttons6, mouse_en, mouse_lbtn, mouse_rbtn} = '0;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_strobe = 1'b0;
		joy_out      = 2'b00;
		{psg_l, psg_r, cdda_l, cdda_r} = '0;
		adpcm        = '0;

		cnt = 0;
		while (rst_n !== 1'b1 && cnt < 100) begin
			@(posedge clk_sys);
			cnt++;
		end
		if (rst_n !== 1'b1) begin
			$display("Reset was never released");
			$display("Testbench failed");
			$finish;
		end else begin
			next_cycle();
			fd = $fopen("dv/pce_io_stimulus.txt", "r");
			if (fd == 0) begin
				$display("Could not open the stimulus file");
				errors++;
			end
			lines = 0;
			while (fd != 0 && !$feof(fd) && lines < 1000) begin
				lines++;
				code = $fgets(line, fd);
				if (code > 0) begin
					code = $sscanf(line, "%s %h %h %h %s", op, a, b, c, name);
				end
				if (code == 5 && op != "#") begin
					case (op)
						"pad": begin
							pad[a[2:0]] = b[11:0];
							next_cycle();
						end
						"cfg": begin  // Bits 5:0 are lbtn, rbtn, swap, tap, 6btn, mouse
							{mouse_lbtn, mouse_rbtn, swap, turbotap, buttons6, mouse_en} = a[5:0];
							next_cycle();
						end
						"joy": begin
							joy_out = a[1:0];
							next_cycle();
						end
						"sel": pulse_joy(0);
						"clr": pulse_joy(1);
						"mse": begin
							mouse_x      = a[8:0];
							mouse_y      = b[8:0];
							mouse_strobe = 1'b1;
							next_cycle();
							mouse_strobe = 1'b0;
							next_cycle();
						end
						"idle": begin
							cnt = 0;
							while (cnt < int'(a) && cnt < 100000) begin
								next_cycle();
								cnt++;
							end
							if (cnt < int'(a)) begin
								errors++;
								$display("Idle of %0d cycles is longer than the limit", a);
							end
						end
						"aul": begin
							psg_l  = a[19:0];
							cdda_l = b[19:0];
							adpcm  = c[15:0];
							next_cycle();
						end
						"aur": begin
							psg_r  = a[19:0];
							cdda_r = b[19:0];
							next_cycle();
						end
						"cjy": compare(name, a, 32'(joy_in));
						"cal": compare(name, a, 32'(audio_l));
						"car": compare(name, a, 32'(audio_r));
						default: begin
							errors++;
							$display("Unknown operation %s in the stimulus file", op);
						end
					endcase
				end else if (code > 0 && op != "#") begin
					errors++;
					$display("Line %0d of the stimulus file has missing fields", lines);
				end
			end
			if (fd != 0) begin
				if (!$feof(fd)) begin
					errors++;
					$display("Stopped reading the stimulus file after %0d lines", lines);
				end
				$fclose(fd);
			end
			$display("Run complete with %0d errors", errors);
			if (errors == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	localparam int RESET_CYCLES = 16;

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;  // 40 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 rst_n = 1'b1;
	end

endmodule

// File: src/pce_io_top.sv
`timescale 1ns/1ps

module pce_io_top (
	input  logic                      clk_sys,
	input  logic                      rst_n,

	// Pads and controller options
	input  pce_io_pkg::pad_buttons_t  pad_0,
	input  pce_io_pkg::pad_buttons_t  pad_1,
	input  pce_io_pkg::pad_buttons_t  pad_2,
	input  pce_io_pkg::pad_buttons_t  pad_3,
	input  pce_io_pkg::pad_buttons_t  pad_4,
	input  logic                      swap,
	input  logic                      turbotap,
	input  logic                      buttons6,
	input  logic                      mouse_en,

	// Host mouse
	input  logic                      mouse_lbtn,
	input  logic                      mouse_rbtn,
	input  logic [8:0]                mouse_x,
	input  logic [8:0]                mouse_y,
	input  logic                      mouse_strobe,

	// Console joypad port
	input  logic [1:0]                joy_out,
	output pce_io_pkg::nibble_t        joy_in,

	// Audio
	input  pce_io_pkg::wide_sample_t  psg_l,
	input  pce_io_pkg::wide_sample_t  psg_r,
	input  pce_io_pkg::wide_sample_t  cdda_l,
	input  pce_io_pkg::wide_sample_t  cdda_r,
	input  pce_io_pkg::adpcm_sample_t adpcm,
	output pce_io_pkg::dac_sample_t   audio_l,
	output pce_io_pkg::dac_sample_t   audio_r
);

	pce_io_pkg::nibble_t mouse_nibble;

	pad_port u_pad_port (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.pad_0        (pad_0),
		.pad_1        (pad_1),
		.pad_2        (pad_2),
		.pad_3        (pad_3),
		.pad_4        (pad_4),
		.swap         (swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.mouse_lbtn   (mouse_lbtn),
		.mouse_rbtn   (mouse_rbtn),
		.mouse_nibble (mouse_nibble),
		.joy_out      (joy_out),
		.joy_in       (joy_in)
	);

	// Mouse steps on the console's clear line
	mouse_port u_mouse_port (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.clr          (joy_out[1]),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.mouse_nibble (mouse_nibble)
	);

	audio_mixer u_audio_mixer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.cdda_l  (cdda_l),
		.cdda_r  (cdda_r),
		.adpcm   (adpcm),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

// File: src/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  pce_io_pkg::wide_sample_t  psg_l,
	input  pce_io_pkg::wide_sample_t  psg_r,
	input  pce_io_pkg::wide_sample_t  cdda_l,
	input  pce_io_pkg::wide_sample_t  cdda_r,
	input  pce_io_pkg::adpcm_sample_t adpcm,   // Mono, goes to both sides
	output pce_io_pkg::dac_sample_t   audio_l,
	output pce_io_pkg::dac_sample_t   audio_r
);

	// Saturate to 20 bits, then flip the sign for offset binary
	function automatic pce_io_pkg::dac_sample_t clamp_to_dac(input pce_io_pkg::mix_sum_t s);
		if (s[21:19] == 3'b000 || s[21:19] == 3'b111) begin
			clamp_to_dac = {~s[21], s[18:0]};
		end else if (s[21]) begin
			clamp_to_dac = '0;   // Negative overflow
		end else begin
			clamp_to_dac = '1;   // Positive overflow
		end
	endfunction

	pce_io_pkg::mix_sum_t adpcm_ext;
	pce_io_pkg::mix_sum_t sum_l;
	pce_io_pkg::mix_sum_t sum_r;

	// ADPCM is scaled up to the PSG range
	assign adpcm_ext = pce_io_pkg::mix_sum_t'(adpcm) <<< pce_io_pkg::ADPCM_SHIFT;

	// ========================================
	// Mixing register
	// ========================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= pce_io_pkg::mix_sum_t'(psg_l) + pce_io_pkg::mix_sum_t'(cdda_l) + adpcm_ext;
			sum_r <= pce_io_pkg::mix_sum_t'(psg_r) + pce_io_pkg::mix_sum_t'(cdda_r) + adpcm_ext;
		end
	end

	assign audio_l = clamp_to_dac(sum_l);  // Zero sum is midscale
	assign audio_r = clamp_to_dac(sum_r);

endmodule

// File: src/mouse_port.sv
`timescale 1ns/1ps

module mouse_port (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               clr,
	input  logic [8:0]         mouse_x,
	input  logic [8:0]         mouse_y,
	input  logic               mouse_strobe,
	output pce_io_pkg::nibble_t mouse_nibble
);

	pce_io_pkg::mouse_phase_t               phase;
	pce_io_pkg::mouse_delta_t               pend_x;
	pce_io_pkg::mouse_delta_t               pend_y;
	pce_io_pkg::mouse_delta_t               pub_x;   // Deltas the console reads
	pce_io_pkg::mouse_delta_t               pub_y;
	logic [pce_io_pkg::MOUSE_TIMEOUT_W-1:0] idle_cnt;
	logic                                   clr_d;
	logic                                   clr_rise;

	assign clr_rise = clr && !clr_d;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clr_d    <= 1'b0;
			idle_cnt <= '0;
			phase    <= pce_io_pkg::Y_LOW;
			pend_x   <= '0;
			pend_y   <= '0;
			pub_x    <= '0;
			pub_y    <= '0;
		end else begin
			clr_d <= clr;

			// Idle timer, held while the console keeps clear high
			if (clr) begin
				idle_cnt <= '0;
			end else if (!(&idle_cnt)) begin
				idle_cnt <= idle_cnt + 1'b1;
			end

			if (&idle_cnt) begin
				phase <= pce_io_pkg::Y_LOW;  // Next clear starts at X_HIGH
			end

			if (clr_rise) begin
				phase <= pce_io_pkg::mouse_phase_t'(phase + 2'd1);
				if (phase == pce_io_pkg::Y_LOW) begin
					pub_x  <= pend_x;  // New group of four
					pub_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// Host X runs the other way round
			if (mouse_strobe) begin
				pend_x <= 8'd0 - mouse_x[7:0];
				pend_y <= mouse_y[7:0];
			end
		end
	end

	always_comb begin
		case (phase)
			pce_io_pkg::X_HIGH: mouse_nibble = pub_x[7:4];
			pce_io_pkg::X_LOW:  mouse_nibble = pub_x[3:0];
			pce_io_pkg::Y_HIGH: mouse_nibble = pub_y[7:4];
			default:            mouse_nibble = pub_y[3:0];
		endcase
	end

endmodule

// File: src/pad_port.sv
`timescale 1ns/1ps

module pad_port (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  pce_io_pkg::pad_buttons_t pad_0,
	input  pce_io_pkg::pad_buttons_t pad_1,
	input  pce_io_pkg::pad_buttons_t pad_2,
	input  pce_io_pkg::pad_buttons_t pad_3,
	input  pce_io_pkg::pad_buttons_t pad_4,
	input  logic                    swap,
	input  logic                    turbotap,
	input  logic                    buttons6,
	input  logic                    mouse_en,
	input  logic                    mouse_lbtn,
	input  logic                    mouse_rbtn,
	input  pce_io_pkg::nibble_t      mouse_nibble,
	input  logic [1:0]              joy_out,      // 0 select, 1 clear
	output pce_io_pkg::nibble_t      joy_in
);

	// Host buttons to the console word. Directions go up, right, down, left
	function automatic pce_io_pkg::pad_word_t pad_to_word(input pce_io_pkg::pad_buttons_t pad);
		pad_to_word = ~{4'hF, pad[11:8], pad[1], pad[2], pad[0], pad[3], pad[7:4]};
	endfunction

	pce_io_pkg::pad_buttons_t pad_a;
	pce_io_pkg::pad_buttons_t pad_b;
	pce_io_pkg::pad_word_t    pad_words [pce_io_pkg::NUM_PADS];
	pce_io_pkg::pad_word_t    sel_word;
	logic [7:0]               mouse_byte;
	pce_io_pkg::port_idx_t    port_idx;
	logic [1:0]               joy_out_d;
	logic                     high_half;  // Six-button extras selected
	logic                     sel;
	logic                     clr;

	assign sel = joy_out[0];
	assign clr = joy_out[1];

	assign pad_a = swap ? pad_1 : pad_0;  // Joystick swap
	assign pad_b = swap ? pad_0 : pad_1;

	// Buttons are inverted like the pad nibbles
	assign mouse_byte = {mouse_nibble, ~{pad_a[7:6], mouse_lbtn, mouse_rbtn}};

	always_comb begin
		pad_words[0] = mouse_en ? {mouse_byte, mouse_byte} : pad_to_word(pad_a);
		pad_words[1] = pad_to_word(pad_b);
		pad_words[2] = pad_to_word(pad_2);
		pad_words[3] = pad_to_word(pad_3);
		pad_words[4] = pad_to_word(pad_4);
	end

	always_comb begin
		if (int'(port_idx) < pce_io_pkg::NUM_PADS) begin
			sel_word = pad_words[port_idx];
		end else begin
			sel_word = pce_io_pkg::IDLE_PAD_WORD;  // Ports 5 to 7
		end
	end

	// ========================================
	// Console side of the port
	// ========================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_in    <= '0;
			joy_out_d <= '0;
			port_idx  <= '0;
			high_half <= 1'b0;
		end else begin
			joy_out_d <= joy_out;
			joy_in    <= sel_word[{high_half, sel, 2'b00} +: 4];

			if (clr) begin
				port_idx <= '0;
				joy_in   <= '0;
				// Each clear edge flips between the two halves of a six-button pad
				if (!joy_out_d[1]) begin
					high_half <= ~high_half && buttons6;
				end
			end else if (sel && !joy_out_d[0] && turbotap) begin
				port_idx <= port_idx + 3'd1;  // Tap steps to the next pad
			end
		end
	end

endmodule

// File: src/pce_io_pkg.sv
package pce_io_pkg;

	// ========================================
	// Pad and joypad port types
	// ========================================

	// 3:0 directions, 7:4 I/II/select/run, 11:8 six-button extras
	typedef logic [11:0] pad_buttons_t;
	typedef logic [15:0] pad_word_t;    // Active low, as the console sees it
	typedef logic [3:0]  nibble_t;
	typedef logic [2:0]  port_idx_t;    // Tap port, 0 to 7

	// ========================================
	// Mouse types
	// ========================================

	typedef logic [7:0] mouse_delta_t;

	// Reading order of the four movement nibbles
	typedef enum logic [1:0] {
		X_HIGH,
		X_LOW,
		Y_HIGH,
		Y_LOW
	} mouse_phase_t;

	// ========================================
	// Audio types
	// ========================================

	typedef logic signed [19:0] wide_sample_t;  // PSG and CD audio
	typedef logic signed [15:0] adpcm_sample_t;
	typedef logic signed [21:0] mix_sum_t;      // Headroom for three sources
	typedef logic [19:0]        dac_sample_t;   // Offset binary

	localparam int        NUM_PADS        = 5;
	localparam pad_word_t IDLE_PAD_WORD   = 16'h0FFF;  // Tap ports with no pad
	localparam int        MOUSE_TIMEOUT_W = 15;
	localparam int        ADPCM_SHIFT     = 4;

endpackage
